// File: Bender.yml
package:
  name: id_stage

sources:
  - hdl/id_pkg.sv
  - hdl/id_decoder.sv
  - hdl/id_operand_sel.sv
  - hdl/id_resolve.sv
  - hdl/id_ex_reg.sv
  - hdl/id_stage.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_id_stage.sv

// File: filelist.f
+incdir+test
hdl/id_pkg.sv
hdl/id_decoder.sv
hdl/id_operand_sel.sv
hdl/id_resolve.sv
hdl/id_ex_reg.sv
hdl/id_stage.sv
test/tb_id_stage.sv

// File: hdl/id_decoder.sv
`timescale 1ns/1ns

module id_decoder
    import id_pkg::*;
(
    input  inst_t    inst_i,
    output id_ctrl_t ctrl_o
);

    opcode_t    opcode;
    funct_t     funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [4:0] shamt;
    alu_op_e    op;
    logic       shift_imm;
    logic       is_store;

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign shamt  = inst_i[10:6];
    assign funct  = inst_i[5:0];

    // sll/srl/sra take the shift amount as operand 0
    assign shift_imm = (opcode == OP_SPECIAL) && (rs == 5'd0) &&
                       (funct inside {FN_SLL, FN_SRL, FN_SRA});
    assign is_store  = opcode inside {OP_SB, OP_SH, OP_SW};

    always_comb begin
        op = ALU_NOP;
        case (opcode)
            OP_SPECIAL: begin
                if (shamt == 5'd0) begin
                    case (funct)
                        FN_AND:  op = ALU_AND;
                        FN_OR:   op = ALU_OR;
                        FN_XOR:  op = ALU_XOR;
                        FN_NOR:  op = ALU_NOR;
                        FN_ADD:  op = ALU_ADD;
                        FN_ADDU: op = ALU_ADDU;
                        FN_SUB:  op = ALU_SUB;
                        FN_SUBU: op = ALU_SUBU;
                        FN_SLT:  op = ALU_SLT;
                        FN_SLTU: op = ALU_SLTU;
                        FN_SLLV: op = ALU_SLL;
                        FN_SRLV: op = ALU_SRL;
                        FN_SRAV: op = ALU_SRA;
                        FN_MOVN: op = ALU_MOVN;
                        FN_MOVZ: op = ALU_MOVZ;
                        FN_JR:   op = ALU_JR;
                        FN_JALR: op = ALU_JALR;
                        default: ;
                    endcase
                end
                if (shift_imm) begin
                    case (funct)
                        FN_SLL:  op = ALU_SLL;
                        FN_SRL:  op = ALU_SRL;
                        default: op = ALU_SRA;
                    endcase
                end
            end
            OP_REGIMM: begin
                case (rt)
                    RT_BLTZ:   op = ALU_BLTZ;
                    RT_BGEZ:   op = ALU_BGEZ;
                    RT_BLTZAL: op = ALU_BLTZAL;
                    RT_BGEZAL: op = ALU_BGEZAL;
                    default: ;
                endcase
            end
            OP_J:     op = ALU_J;
            OP_JAL:   op = ALU_JAL;
            OP_BEQ:   op = ALU_BEQ;
            OP_BNE:   op = ALU_BNE;
            OP_BLEZ:  op = ALU_BLEZ;
            OP_BGTZ:  op = ALU_BGTZ;
            OP_ADDI:  op = ALU_ADDI;
            OP_ADDIU: op = ALU_ADDIU;
            OP_SLTI:  op = ALU_SLT;
            OP_SLTIU: op = ALU_SLTU;
            OP_ANDI:  op = ALU_AND;
            OP_ORI:   op = ALU_OR;
            OP_XORI:  op = ALU_XOR;
            OP_LUI:   op = ALU_OR;     // or with $0
            OP_LB:    op = ALU_LB;
            OP_LH:    op = ALU_LH;
            OP_LW:    op = ALU_LW;
            OP_LBU:   op = ALU_LBU;
            OP_LHU:   op = ALU_LHU;
            OP_SB:    op = ALU_SB;
            OP_SH:    op = ALU_SH;
            OP_SW:    op = ALU_SW;
            default: ;
        endcase
    end

    always_comb begin
        ctrl_o            = '0;
        ctrl_o.alu_op     = op;
        ctrl_o.rd_addr[0] = rs;
        ctrl_o.rd_addr[1] = rt;
        ctrl_o.cond_move  = op inside {ALU_MOVN, ALU_MOVZ};

        case (op)
            ALU_J:      ctrl_o.br_kind = BR_J;
            ALU_JAL:    ctrl_o.br_kind = BR_J;
            ALU_JR:     ctrl_o.br_kind = BR_JR;
            ALU_JALR:   ctrl_o.br_kind = BR_JR;
            ALU_BEQ:    ctrl_o.br_kind = BR_BEQ;
            ALU_BNE:    ctrl_o.br_kind = BR_BNE;
            ALU_BGTZ:   ctrl_o.br_kind = BR_BGTZ;
            ALU_BLEZ:   ctrl_o.br_kind = BR_BLEZ;
            ALU_BGEZ, ALU_BGEZAL: ctrl_o.br_kind = BR_BGEZ;
            ALU_BLTZ, ALU_BLTZAL: ctrl_o.br_kind = BR_BLTZ;
            default: ;
        endcase
        ctrl_o.link = op inside {ALU_JAL, ALU_JALR, ALU_BGEZAL, ALU_BLTZAL};

        case (op)
            ALU_AND, ALU_OR, ALU_XOR, ALU_NOR: begin
                ctrl_o.alu_sel = SEL_LOGIC;
                ctrl_o.wreg    = 1'b1;
            end
            ALU_SLL, ALU_SRL, ALU_SRA: begin
                ctrl_o.alu_sel = SEL_SHIFT;
                ctrl_o.wreg    = 1'b1;
            end
            ALU_MOVN, ALU_MOVZ: begin
                ctrl_o.alu_sel = SEL_MOVE;
                ctrl_o.wreg    = 1'b1;    // gated later on rt
            end
            ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU, ALU_ADDI, ALU_ADDIU: begin
                ctrl_o.alu_sel = SEL_ARITH;
                ctrl_o.wreg    = 1'b1;
            end
            ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW: begin
                ctrl_o.alu_sel = SEL_LOAD_STORE;
                ctrl_o.wreg    = 1'b1;
            end
            ALU_SB, ALU_SH, ALU_SW: ctrl_o.alu_sel = SEL_LOAD_STORE;
            ALU_NOP: ;
            default: begin
                ctrl_o.alu_sel = SEL_JUMP_BRANCH;
                ctrl_o.wreg    = ctrl_o.link;
            end
        endcase

        if (!ctrl_o.wreg)
            ctrl_o.wd = NOP_REG;
        else if (ctrl_o.link && op != ALU_JALR)
            ctrl_o.wd = LINK_REG;
        else if (opcode == OP_SPECIAL)
            ctrl_o.wd = rd;
        else
            ctrl_o.wd = rt;

        ctrl_o.rd_en[0] = (op != ALU_NOP) && (ctrl_o.br_kind != BR_J) && !shift_imm;
        ctrl_o.rd_en[1] = ((opcode == OP_SPECIAL) && (op != ALU_NOP) &&
                           (ctrl_o.br_kind != BR_JR)) ||
                          (ctrl_o.br_kind inside {BR_BEQ, BR_BNE}) || is_store;

        case (opcode)
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU:
                ctrl_o.imm = {{16{inst_i[15]}}, inst_i[15:0]};
            OP_ANDI, OP_ORI, OP_XORI:
                ctrl_o.imm = {16'h0, inst_i[15:0]};
            OP_LUI:
                ctrl_o.imm = {inst_i[15:0], 16'h0};
            default:
                ctrl_o.imm = shift_imm ? {27'd0, shamt} : '0;
        endcase
    end

endmodule

// File: hdl/id_ex_reg.sv
`timescale 1ns/1ns

module id_ex_reg
    import id_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n_i,
    input  logic   stall_i,
    input  id_ex_t d_i,
    output id_ex_t q_o,
    output logic   ex_is_load_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_o <= ID_EX_BUBBLE;
        end else if (stall_i) begin
            q_o <= ID_EX_BUBBLE;   // held instruction decodes again next cycle
        end else begin
            q_o <= d_i;
        end
    end

    // bubble clears this, so a load-use stall is one cycle
    assign ex_is_load_o = q_o.alu_op inside {ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW};

    a_stall_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        stall_i |=> !stall_i
    ) else $error("load-use stall longer than one cycle");

endmodule

// File: hdl/id_operand_sel.sv
`timescale 1ns/1ns

module id_operand_sel
    import id_pkg::*;
(
    input  logic      rd_en_i,
    input  reg_addr_t rd_addr_i,
    input  word_t     imm_i,
    input  word_t     reg_data_i,
    input  wb_fwd_t   ex_fwd_i,
    input  wb_fwd_t   mem_fwd_i,
    input  logic      ex_is_load_i,
    output word_t     operand_o,
    output logic      load_stall_o
);

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = ex_fwd_i.wd == rd_addr_i;
    assign mem_hit = mem_fwd_i.wreg && (mem_fwd_i.wd == rd_addr_i);

    always_comb begin
        load_stall_o = 1'b0;
        operand_o    = imm_i;     // unread source
        if (rd_en_i) begin
            if (ex_is_load_i && ex_hit) begin
                load_stall_o = 1'b1;
                operand_o    = '0;  // load data not there yet
            end else if (ex_fwd_i.wreg && ex_hit) begin
                operand_o = ex_fwd_i.wdata;
            end else if (mem_hit) begin
                operand_o = mem_fwd_i.wdata;
            end else begin
                operand_o = reg_data_i;
            end
        end
    end

endmodule

// File: hdl/id_pkg.sv
package id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_REGIMM  = 6'b000001;
    localparam opcode_t OP_J       = 6'b000010;
    localparam opcode_t OP_JAL     = 6'b000011;
    localparam opcode_t OP_BEQ     = 6'b000100;
    localparam opcode_t OP_BNE     = 6'b000101;
    localparam opcode_t OP_BLEZ    = 6'b000110;
    localparam opcode_t OP_BGTZ    = 6'b000111;
    localparam opcode_t OP_ADDI    = 6'b001000;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;
    localparam opcode_t OP_LB      = 6'b100000;
    localparam opcode_t OP_LH      = 6'b100001;
    localparam opcode_t OP_LW      = 6'b100011;
    localparam opcode_t OP_LBU     = 6'b100100;
    localparam opcode_t OP_LHU     = 6'b100101;
    localparam opcode_t OP_SB      = 6'b101000;
    localparam opcode_t OP_SH      = 6'b101001;
    localparam opcode_t OP_SW      = 6'b101011;

    localparam funct_t FN_SLL  = 6'b000000;
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_SRA  = 6'b000011;
    localparam funct_t FN_SLLV = 6'b000100;
    localparam funct_t FN_SRLV = 6'b000110;
    localparam funct_t FN_SRAV = 6'b000111;
    localparam funct_t FN_JR   = 6'b001000;
    localparam funct_t FN_JALR = 6'b001001;
    localparam funct_t FN_MOVZ = 6'b001010;
    localparam funct_t FN_MOVN = 6'b001011;
    localparam funct_t FN_ADD  = 6'b100000;
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUB  = 6'b100010;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_NOR  = 6'b100111;
    localparam funct_t FN_SLT  = 6'b101010;
    localparam funct_t FN_SLTU = 6'b101011;

    // rt field under REGIMM
    localparam reg_addr_t RT_BLTZ   = 5'b00000;
    localparam reg_addr_t RT_BGEZ   = 5'b00001;
    localparam reg_addr_t RT_BLTZAL = 5'b10000;
    localparam reg_addr_t RT_BGEZAL = 5'b10001;

    localparam reg_addr_t LINK_REG = 5'd31;
    localparam reg_addr_t NOP_REG  = 5'd0;

    typedef enum logic [7:0] {
        ALU_NOP    = 8'h00,
        ALU_AND    = 8'h24, ALU_OR     = 8'h25, ALU_XOR   = 8'h26, ALU_NOR   = 8'h27,
        ALU_SLL    = 8'h7c, ALU_SRL    = 8'h02, ALU_SRA   = 8'h03,
        ALU_MOVZ   = 8'h0a, ALU_MOVN   = 8'h0b,
        ALU_SLT    = 8'h2a, ALU_SLTU   = 8'h2b, ALU_ADDI  = 8'h55, ALU_ADDIU = 8'h56,
        ALU_ADD    = 8'h20, ALU_ADDU   = 8'h21, ALU_SUB   = 8'h22, ALU_SUBU  = 8'h23,
        ALU_J      = 8'h4f, ALU_JAL    = 8'h50, ALU_JALR  = 8'h09, ALU_JR    = 8'h08,
        ALU_BEQ    = 8'h51, ALU_BNE    = 8'h52, ALU_BLEZ  = 8'h53, ALU_BGTZ  = 8'h54,
        ALU_BGEZ   = 8'h41, ALU_BGEZAL = 8'h4b, ALU_BLTZ  = 8'h40, ALU_BLTZAL = 8'h4a,
        ALU_LB     = 8'he0, ALU_LBU    = 8'he4, ALU_LH    = 8'he1, ALU_LHU   = 8'he5,
        ALU_LW     = 8'he3, ALU_SB     = 8'he8, ALU_SH    = 8'he9, ALU_SW    = 8'heb
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP         = 3'b000,
        SEL_LOGIC       = 3'b001,
        SEL_SHIFT       = 3'b010,
        SEL_MOVE        = 3'b011,
        SEL_ARITH       = 3'b100,
        SEL_JUMP_BRANCH = 3'b110,
        SEL_LOAD_STORE  = 3'b111
    } alu_sel_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_J, BR_JR, BR_BEQ, BR_BNE, BR_BGTZ, BR_BLEZ, BR_BGEZ, BR_BLTZ
    } br_kind_e;

    typedef struct packed {
        logic      wreg;
        reg_addr_t wd;
        word_t     wdata;
    } wb_fwd_t;

    typedef struct packed {
        alu_op_e               alu_op;
        alu_sel_e              alu_sel;
        logic                  wreg;
        reg_addr_t             wd;
        logic      [1:0]       rd_en;     // [0] rs, [1] rt
        reg_addr_t [1:0]       rd_addr;
        word_t                 imm;
        br_kind_e              br_kind;
        logic                  link;
        logic                  cond_move;
    } id_ctrl_t;

    typedef struct packed {
        alu_op_e   alu_op;
        alu_sel_e  alu_sel;
        word_t     reg1;
        word_t     reg2;
        reg_addr_t wd;
        logic      wreg;
        word_t     link_addr;
        logic      in_delayslot;
        inst_t     inst;
    } id_ex_t;

    localparam id_ex_t ID_EX_BUBBLE = '0;

endpackage

// File: hdl/id_resolve.sv
`timescale 1ns/1ns

module id_resolve
    import id_pkg::*;
(
    input  word_t        pc_i,
    input  inst_t        inst_i,
    input  id_ctrl_t     ctrl_i,
    input  word_t [1:0]  operand_i,
    output logic         wreg_o,
    output logic         branch_flag_o,
    output word_t        branch_target_o,
    output word_t        link_addr_o,
    output logic         next_in_delayslot_o
);

    word_t pc_plus_4;
    word_t br_offset;
    logic  op0_zero;
    logic  op1_zero;

    assign pc_plus_4 = pc_i + 32'd4;
    assign br_offset = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
    assign op0_zero  = operand_i[0] == '0;
    assign op1_zero  = operand_i[1] == '0;

    always_comb begin
        case (ctrl_i.br_kind)
            BR_J, BR_JR: branch_flag_o = 1'b1;
            BR_BEQ:      branch_flag_o = operand_i[0] == operand_i[1];
            BR_BNE:      branch_flag_o = operand_i[0] != operand_i[1];
            BR_BGTZ:     branch_flag_o = !operand_i[0][31] && !op0_zero;
            BR_BLEZ:     branch_flag_o = operand_i[0][31] || op0_zero;
            BR_BGEZ:     branch_flag_o = !operand_i[0][31];
            BR_BLTZ:     branch_flag_o = operand_i[0][31];
            default:     branch_flag_o = 1'b0;
        endcase

        if (!branch_flag_o)
            branch_target_o = '0;
        else if (ctrl_i.br_kind == BR_J)
            branch_target_o = {pc_plus_4[31:28], inst_i[25:0], 2'b00};
        else if (ctrl_i.br_kind == BR_JR)
            branch_target_o = operand_i[0];
        else
            branch_target_o = pc_plus_4 + br_offset;
    end

    assign next_in_delayslot_o = branch_flag_o;
    assign link_addr_o         = ctrl_i.link ? pc_i + 32'd8 : '0;

    // movn writes on nonzero rt, movz on zero rt
    always_comb begin
        if (ctrl_i.cond_move)
            wreg_o = (ctrl_i.alu_op == ALU_MOVN) ? !op1_zero : op1_zero;
        else
            wreg_o = ctrl_i.wreg;
    end

    a_branch_class: assert final (!branch_flag_o || ctrl_i.alu_sel == SEL_JUMP_BRANCH)
        else $error("branch taken outside the jump/branch class");

endmodule

// File: hdl/id_stage.sv
`timescale 1ns/1ns

module id_stage
    import id_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n_i,
    input  word_t            pc_i,
    input  inst_t            inst_i,
    input  logic             is_in_delayslot_i,
    input  word_t     [1:0]  reg_data_i,
    input  wb_fwd_t          ex_fwd_i,
    input  wb_fwd_t          mem_fwd_i,
    output logic      [1:0]  reg_rd_en_o,
    output reg_addr_t [1:0]  reg_rd_addr_o,
    output id_ex_t           id_ex_o,
    output logic             branch_flag_o,
    output word_t            branch_target_o,
    output logic             next_in_delayslot_o,
    output logic             stall_o
);

    id_ctrl_t    ctrl;
    word_t [1:0] operand;
    logic  [1:0] load_stall;
    logic        ex_is_load;
    logic        wreg;
    word_t       link_addr;
    id_ex_t      id_ex_d;

    id_decoder i_decoder (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    for (genvar k = 0; k < 2; k++) begin : g_operand
        id_operand_sel i_operand_sel (
            .rd_en_i      (ctrl.rd_en[k]),
            .rd_addr_i    (ctrl.rd_addr[k]),
            .imm_i        (ctrl.imm),
            .reg_data_i   (reg_data_i[k]),
            .ex_fwd_i     (ex_fwd_i),
            .mem_fwd_i    (mem_fwd_i),
            .ex_is_load_i (ex_is_load),
            .operand_o    (operand[k]),
            .load_stall_o (load_stall[k])
        );
    end

    id_resolve i_resolve (
        .pc_i                (pc_i),
        .inst_i              (inst_i),
        .ctrl_i              (ctrl),
        .operand_i           (operand),
        .wreg_o              (wreg),
        .branch_flag_o       (branch_flag_o),
        .branch_target_o     (branch_target_o),
        .link_addr_o         (link_addr),
        .next_in_delayslot_o (next_in_delayslot_o)
    );

    always_comb begin
        id_ex_d.alu_op       = ctrl.alu_op;
        id_ex_d.alu_sel      = ctrl.alu_sel;
        id_ex_d.reg1         = operand[0];
        id_ex_d.reg2         = operand[1];
        id_ex_d.wd           = ctrl.wd;
        id_ex_d.wreg         = wreg;
        id_ex_d.link_addr    = link_addr;
        id_ex_d.in_delayslot = is_in_delayslot_i;
        id_ex_d.inst         = inst_i;
    end

    assign stall_o       = |load_stall;
    assign reg_rd_en_o   = ctrl.rd_en;
    assign reg_rd_addr_o = ctrl.rd_addr;

    id_ex_reg i_id_ex_reg (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .stall_i      (stall_o),
        .d_i          (id_ex_d),
        .q_o          (id_ex_o),
        .ex_is_load_o (ex_is_load)
    );

endmodule

// File: test/tb_id_model.svh
`ifndef TB_ID_MODEL_SVH
`define TB_ID_MODEL_SVH

typedef struct packed {
    logic      [1:0] rd_en;
    reg_addr_t [1:0] rd_addr;
    logic            branch_flag;
    word_t           branch_target;
    logic            next_in_delayslot;
    logic            stall;
    id_ex_t          next;              // bundle captured at the coming edge
} expect_t;

function automatic logic is_load_op(alu_op_e op);
    return op inside {ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW};
endfunction

// expected decode response for one set of inputs
function automatic expect_t decode_expected(inst_t ins, word_t pc_v, word_t [1:0] rdata,
                                            wb_fwd_t ex_f, wb_fwd_t mem_f, logic in_ds,
                                            logic ex_load);
    expect_t     e;
    opcode_t     opc;
    funct_t      fn;
    reg_addr_t   rs;
    reg_addr_t   rt;
    logic        shift_by_sa;
    alu_op_e     op;
    alu_sel_e    sel;
    logic        link;
    logic        wreg;
    reg_addr_t   wd;
    word_t       imm;
    word_t [1:0] opnd;
    logic  [1:0] stall;
    word_t       pc4;
    int          k;

    e   = '0;
    opc = ins[31:26];
    rs  = ins[25:21];
    rt  = ins[20:16];
    fn  = ins[5:0];
    op  = ALU_NOP;
    shift_by_sa = (opc == OP_SPECIAL) && (rs == 5'd0) && (fn inside {FN_SLL, FN_SRL, FN_SRA});

    case (opc)
        OP_SPECIAL: begin
            if (shift_by_sa)
                op = (fn == FN_SLL) ? ALU_SLL : ((fn == FN_SRL) ? ALU_SRL : ALU_SRA);
            else if (ins[10:6] == 5'd0) begin
                case (fn)
                    FN_AND:  op = ALU_AND;
                    FN_OR:   op = ALU_OR;
                    FN_XOR:  op = ALU_XOR;
                    FN_NOR:  op = ALU_NOR;
                    FN_ADD:  op = ALU_ADD;
                    FN_ADDU: op = ALU_ADDU;
                    FN_SUB:  op = ALU_SUB;
                    FN_SUBU: op = ALU_SUBU;
                    FN_SLT:  op = ALU_SLT;
                    FN_SLTU: op = ALU_SLTU;
                    FN_SLLV: op = ALU_SLL;
                    FN_SRLV: op = ALU_SRL;
                    FN_SRAV: op = ALU_SRA;
                    FN_MOVN: op = ALU_MOVN;
                    FN_MOVZ: op = ALU_MOVZ;
                    FN_JR:   op = ALU_JR;
                    FN_JALR: op = ALU_JALR;
                    default: ;
                endcase
            end
        end
        OP_REGIMM: begin
            case (rt)
                RT_BLTZ:   op = ALU_BLTZ;
                RT_BGEZ:   op = ALU_BGEZ;
                RT_BLTZAL: op = ALU_BLTZAL;
                RT_BGEZAL: op = ALU_BGEZAL;
                default: ;
            endcase
        end
        OP_J:     op = ALU_J;
        OP_JAL:   op = ALU_JAL;
        OP_BEQ:   op = ALU_BEQ;
        OP_BNE:   op = ALU_BNE;
        OP_BLEZ:  op = ALU_BLEZ;
        OP_BGTZ:  op = ALU_BGTZ;
        OP_ADDI:  op = ALU_ADDI;
        OP_ADDIU: op = ALU_ADDIU;
        OP_SLTI:  op = ALU_SLT;
        OP_SLTIU: op = ALU_SLTU;
        OP_ANDI:  op = ALU_AND;
        OP_ORI:   op = ALU_OR;
        OP_XORI:  op = ALU_XOR;
        OP_LUI:   op = ALU_OR;
        OP_LB:    op = ALU_LB;
        OP_LH:    op = ALU_LH;
        OP_LW:    op = ALU_LW;
        OP_LBU:   op = ALU_LBU;
        OP_LHU:   op = ALU_LHU;
        OP_SB:    op = ALU_SB;
        OP_SH:    op = ALU_SH;
        OP_SW:    op = ALU_SW;
        default: ;
    endcase

    link = op inside {ALU_JAL, ALU_JALR, ALU_BGEZAL, ALU_BLTZAL};
    if (op inside {ALU_AND, ALU_OR, ALU_XOR, ALU_NOR})
        sel = SEL_LOGIC;
    else if (op inside {ALU_SLL, ALU_SRL, ALU_SRA})
        sel = SEL_SHIFT;
    else if (op inside {ALU_MOVN, ALU_MOVZ})
        sel = SEL_MOVE;
    else if (op inside {ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
                        ALU_ADDI, ALU_ADDIU})
        sel = SEL_ARITH;
    else if (is_load_op(op) || (op inside {ALU_SB, ALU_SH, ALU_SW}))
        sel = SEL_LOAD_STORE;
    else if (op == ALU_NOP)
        sel = SEL_NOP;
    else
        sel = SEL_JUMP_BRANCH;

    if (sel == SEL_JUMP_BRANCH)
        wreg = link;
    else
        wreg = (op != ALU_NOP) && !(op inside {ALU_SB, ALU_SH, ALU_SW});
    if (!wreg)
        wd = NOP_REG;
    else if (link && op != ALU_JALR)
        wd = LINK_REG;
    else
        wd = (opc == OP_SPECIAL) ? ins[15:11] : rt;

    e.rd_addr[0] = rs;
    e.rd_addr[1] = rt;
    e.rd_en[0]   = (op != ALU_NOP) && !(op inside {ALU_J, ALU_JAL}) && !shift_by_sa;
    e.rd_en[1]   = ((opc == OP_SPECIAL) && (op != ALU_NOP) && !(op inside {ALU_JR, ALU_JALR}))
                   || (op inside {ALU_BEQ, ALU_BNE, ALU_SB, ALU_SH, ALU_SW});

    case (opc)
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: imm = {{16{ins[15]}}, ins[15:0]};
        OP_ANDI, OP_ORI, OP_XORI:             imm = {16'h0000, ins[15:0]};
        OP_LUI:                               imm = {ins[15:0], 16'h0000};
        default:                              imm = shift_by_sa ? {27'd0, ins[10:6]} : '0;
    endcase

    // EX load first, then EX, MEM, register file
    for (k = 0; k < 2; k++) begin
        stall[k] = e.rd_en[k] && ex_load && (ex_f.wd == e.rd_addr[k]);
        if (!e.rd_en[k])
            opnd[k] = imm;
        else if (stall[k])
            opnd[k] = '0;
        else if (ex_f.wreg && ex_f.wd == e.rd_addr[k])
            opnd[k] = ex_f.wdata;
        else if (mem_f.wreg && mem_f.wd == e.rd_addr[k])
            opnd[k] = mem_f.wdata;
        else
            opnd[k] = rdata[k];
    end

    case (op)
        ALU_J, ALU_JAL, ALU_JR, ALU_JALR: e.branch_flag = 1'b1;
        ALU_BEQ:                          e.branch_flag = opnd[0] == opnd[1];
        ALU_BNE:                          e.branch_flag = opnd[0] != opnd[1];
        ALU_BGTZ:                         e.branch_flag = $signed(opnd[0]) > 0;
        ALU_BLEZ:                         e.branch_flag = $signed(opnd[0]) <= 0;
        ALU_BGEZ, ALU_BGEZAL:             e.branch_flag = $signed(opnd[0]) >= 0;
        ALU_BLTZ, ALU_BLTZAL:             e.branch_flag = $signed(opnd[0]) < 0;
        default:                          e.branch_flag = 1'b0;
    endcase
    pc4 = pc_v + 32'd4;
    if (!e.branch_flag)
        e.branch_target = '0;
    else if (op inside {ALU_J, ALU_JAL})
        e.branch_target = {pc4[31:28], ins[25:0], 2'b00};
    else if (op inside {ALU_JR, ALU_JALR})
        e.branch_target = opnd[0];
    else
        e.branch_target = pc4 + {{14{ins[15]}}, ins[15:0], 2'b00};
    e.next_in_delayslot = e.branch_flag;

    if (op == ALU_MOVN)
        wreg = opnd[1] != '0;
    else if (op == ALU_MOVZ)
        wreg = opnd[1] == '0;

    e.stall = |stall;
    if (!e.stall) begin
        e.next.alu_op       = op;
        e.next.alu_sel      = sel;
        e.next.reg1         = opnd[0];
        e.next.reg2         = opnd[1];
        e.next.wd           = wd;
        e.next.wreg         = wreg;
        e.next.link_addr    = link ? pc_v + 32'd8 : '0;
        e.next.in_delayslot = in_ds;
        e.next.inst         = ins;
    end
    return e;
endfunction

task automatic check_value(input string what, input logic [255:0] got,
                           input logic [255:0] exp);
    n_checks++;
    if (got !== exp) begin
        $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        $display("Testbench failed");
        $fatal(1, "stopped at the first wrong value");
    end
endtask

`endif

// File: test/tb_id_stage.sv
`timescale 1ns/1ns

module tb_id_stage
    import id_pkg::*;
();

    localparam int N_CYCLES       = 2000;
    localparam int RESET_CYCLES   = 10;
    localparam int DRIVE_DELAY    = 2;
    localparam int TIMEOUT_CYCLES = 2 * N_CYCLES;
    localparam logic [31:0] SEED  = 32'h3458;

    // encoding pools of 6 or 5 bits per entry
    localparam logic [17*6-1:0] R_FUNCTS = {FN_AND, FN_OR, FN_XOR, FN_NOR, FN_ADD, FN_ADDU,
        FN_SUB, FN_SUBU, FN_SLT, FN_SLTU, FN_SLLV, FN_SRLV, FN_SRAV, FN_MOVN, FN_MOVZ,
        FN_JR, FN_JALR};
    localparam logic [3*6-1:0]  SH_FUNCTS = {FN_SLL, FN_SRL, FN_SRA};
    localparam logic [16*6-1:0] I_OPS = {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI,
        OP_ORI, OP_XORI, OP_LUI, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};
    localparam logic [6*6-1:0]  B_OPS = {OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ};
    localparam logic [4*5-1:0]  RT_CODES = {RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL};
    // mult, multu, div, divu, mfhi, mthi, mflo, mtlo, sync
    localparam logic [9*6-1:0]  DROP_FNS = {6'h18, 6'h19, 6'h1a, 6'h1b, 6'h10, 6'h11,
        6'h12, 6'h13, 6'h0f};
    // special2, ll, sc, lwl, lwr, swl, swr, pref
    localparam logic [8*6-1:0]  DROP_OPS = {6'h1c, 6'h30, 6'h38, 6'h22, 6'h26, 6'h2a,
        6'h2e, 6'h33};

    logic              clk = 1'b0;
    logic              rst_n;
    word_t             pc;
    inst_t             inst;
    logic              in_delayslot;
    word_t     [1:0]   reg_data;
    wb_fwd_t           ex_fwd;
    wb_fwd_t           mem_fwd;
    logic      [1:0]   reg_rd_en;
    reg_addr_t [1:0]   reg_rd_addr;
    id_ex_t            id_ex;
    logic              branch_flag;
    word_t             branch_target;
    logic              next_in_delayslot;
    logic              stall;

    id_ex_t            exp_q;       // bundle the DUT should hold now
    logic              last_stall;
    logic              last_branch;
    int                n_checks;
    int                n_stalls;
    int                n_taken;
    int                cycle_cnt;

    `include "tb_id_model.svh"

    id_stage i_dut (
        .clk                 (clk),
        .rst_n_i             (rst_n),
        .pc_i                (pc),
        .inst_i              (inst),
        .is_in_delayslot_i   (in_delayslot),
        .reg_data_i          (reg_data),
        .ex_fwd_i            (ex_fwd),
        .mem_fwd_i           (mem_fwd),
        .reg_rd_en_o         (reg_rd_en),
        .reg_rd_addr_o       (reg_rd_addr),
        .id_ex_o             (id_ex),
        .branch_flag_o       (branch_flag),
        .branch_target_o     (branch_target),
        .next_in_delayslot_o (next_in_delayslot),
        .stall_o             (stall)
    );

    always #20 clk = ~clk;

    function automatic inst_t pick_inst();
        word_t     rnd;
        word_t     fld;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        inst_t     ins;

        rnd = $urandom;
        fld = $urandom;
        rs  = {2'b00, fld[2:0]};    // few registers, so bypasses hit often
        rt  = {2'b00, fld[5:3]};
        rd  = {2'b00, fld[8:6]};
        case (rnd[2:0])
            3'd0, 3'd1: ins = {OP_SPECIAL, rs, rt, rd, 5'd0, R_FUNCTS[6*(rnd[31:8] % 17) +: 6]};
            3'd2:       ins = {OP_SPECIAL, 5'd0, rt, rd, fld[13:9],
                               SH_FUNCTS[6*(rnd[31:8] % 3) +: 6]};
            3'd3, 3'd4: ins = {I_OPS[6*(rnd[31:8] % 16) +: 6], rs, rt, fld[31:16]};
            3'd5: begin
                if (rnd[3])
                    ins = {OP_REGIMM, rs, RT_CODES[5*(rnd[31:8] % 4) +: 5], fld[31:16]};
                else
                    ins = {B_OPS[6*(rnd[31:8] % 6) +: 6], rs, rt, fld[31:16]};
            end
            3'd6: begin
                if (rnd[3])
                    ins = {OP_SPECIAL, rs, rt, rd, 5'd0, DROP_FNS[6*(rnd[31:8] % 9) +: 6]};
                else
                    ins = {DROP_OPS[6*(rnd[31:8] % 8) +: 6], rs, rt, fld[31:16]};
            end
            default:    ins = $urandom;   // any encoding at all
        endcase
        return ins;
    endfunction

    task automatic drive_inputs();
        word_t rnd;

        if (!last_stall) begin       // fetch holds on a stall
            inst         = pick_inst();
            rnd          = $urandom;
            pc           = {rnd[31:2], 2'b00};
            in_delayslot = last_branch;
        end
        rnd           = $urandom;
        reg_data[0]   = (rnd[1:0] == 2'b00) ? '0 : $urandom;
        reg_data[1]   = (rnd[3:2] == 2'b00) ? '0 : $urandom;
        ex_fwd.wreg   = exp_q.wreg;  // EX works on the registered bundle
        ex_fwd.wd     = exp_q.wd;
        ex_fwd.wdata  = $urandom;
        if (rnd[6:4] == 3'd0) begin
            ex_fwd.wreg = rnd[7];
            ex_fwd.wd   = {2'b00, rnd[10:8]};
        end
        mem_fwd.wreg  = rnd[11];
        mem_fwd.wd    = {2'b00, rnd[14:12]};
        mem_fwd.wdata = $urandom;
    endtask

    // inputs settle 2 ns after the rising edge, so the falling edge is a safe sample point
    always @(negedge clk) begin : compare
        expect_t e;
        if (!rst_n) begin
            check_value("id_ex_o during reset", id_ex, '0);
            exp_q = '0;
        end else begin
            check_value("id_ex_o", id_ex, exp_q);
            e = decode_expected(inst, pc, reg_data, ex_fwd, mem_fwd, in_delayslot,
                                is_load_op(exp_q.alu_op));
            check_value("reg_rd_en_o", reg_rd_en, e.rd_en);
            check_value("reg_rd_addr_o", reg_rd_addr, e.rd_addr);
            check_value("branch_flag_o", branch_flag, e.branch_flag);
            check_value("branch_target_o", branch_target, e.branch_target);
            check_value("next_in_delayslot_o", next_in_delayslot, e.next_in_delayslot);
            check_value("stall_o", stall, e.stall);
            if (e.stall)
                n_stalls++;
            if (e.branch_flag)
                n_taken++;
            last_stall  = e.stall;
            last_branch = e.branch_flag;
            exp_q       = e.next;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    initial begin : stimulus
        rst_n        = 1'b0;
        pc           = '0;
        inst         = '0;
        in_delayslot = 1'b0;
        reg_data     = '0;
        ex_fwd       = '0;
        mem_fwd      = '0;
        exp_q        = '0;
        last_stall   = 1'b0;
        last_branch  = 1'b0;
        n_checks     = 0;
        n_stalls     = 0;
        n_taken      = 0;
        cycle_cnt    = 0;
        void'($urandom(SEED));

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        for (int i = 0; i < N_CYCLES; i++) begin
            drive_inputs();
            @(posedge clk);
            #DRIVE_DELAY;
        end
        @(negedge clk);  // last captured bundle gets compared here
        #1;

        if (n_stalls == 0 || n_taken == 0) begin
            $display("No load-use stall or no taken branch came up in %0d cycles", N_CYCLES);
            $display("Testbench failed");
            $fatal(1, "stimulus missed the stall or branch cases");
        end else begin
            $display("%0d checks, %0d stalls, %0d taken branches", n_checks, n_stalls, n_taken);
            $display("Testbench passed");
            $finish;
        end
    end

endmodule
